// ==== scoreboard_pkg.sv ====
package scoreboard_pkg;

    // widths
    localparam int num_players = 2;
    localparam int color_w     = 2;
    localparam int score_w     = 3;
    localparam int rgb_w       = 3;  // red, green, blue
    localparam int seg_w       = 7;
    localparam int num_digits  = 8;
    localparam int digit_sel_w = 3;
    localparam int msg_w       = 2;
    localparam int lcd_data_w  = 8;
    localparam int lcd_cols    = 16; // characters per line
    localparam int col_w       = 5;  // slot 0 is the address write
    localparam int interval_w  = 9;  // wide enough for home_cycles

    // colour codes
    localparam logic [color_w-1:0] color_off   = 2'd0;
    localparam logic [color_w-1:0] color_red   = 2'd1;
    localparam logic [color_w-1:0] color_green = 2'd2;
    localparam logic [color_w-1:0] color_blue  = 2'd3;

    // seven segment, active low, a..g
    localparam logic [seg_w-1:0] seg_blank = 7'b111_1111;
    localparam logic [seg_w-1:0] seg_digit [0:5] = '{
        7'b111_1111,  // unused, blank
        7'b100_1111,  // 1
        7'b001_0010,  // 2
        7'b000_0110,  // 3
        7'b100_1100,  // 4
        7'b010_0100   // 5
    };

    // banner selection
    localparam logic [msg_w-1:0] msg_p1_win = 2'd1;
    localparam logic [msg_w-1:0] msg_p2_win = 2'd2;

    // lcd commands
    localparam logic [lcd_data_w-1:0] cmd_function_set = 8'h3C;
    localparam logic [lcd_data_w-1:0] cmd_entry_mode   = 8'h06;
    localparam logic [lcd_data_w-1:0] cmd_display_on   = 8'h0C;
    localparam logic [lcd_data_w-1:0] cmd_line1_addr   = 8'h80;
    localparam logic [lcd_data_w-1:0] cmd_line2_addr   = 8'hC0;
    localparam logic [lcd_data_w-1:0] cmd_return_home  = 8'h02;
    localparam logic [lcd_data_w-1:0] cmd_clear        = 8'h01;

    // characters
    localparam logic [lcd_data_w-1:0] chr_space = 8'h20;
    localparam logic [lcd_data_w-1:0] chr_heart = 8'h9D; // from the lcd rom
    localparam logic [lcd_data_w-1:0] chr_p     = 8'h50;
    localparam logic [lcd_data_w-1:0] chr_w     = 8'h57;
    localparam logic [lcd_data_w-1:0] chr_i     = 8'h69;
    localparam logic [lcd_data_w-1:0] chr_n     = 8'h6E;
    localparam logic [lcd_data_w-1:0] chr_1     = 8'h31;
    localparam logic [lcd_data_w-1:0] chr_2     = 8'h32;

    // state lengths in clock cycles
    localparam int powerup_cycles = 71;
    localparam int init_cycles    = 31;
    localparam int line_cycles    = 21;
    localparam int home_cycles    = 401;
    localparam int clear_cycles   = 201;

    typedef enum logic [2:0] {
        powerup,
        function_set,
        entry_mode,
        display_on,
        line1,
        line2,
        return_home,
        clear
    } lcd_state_t;

endpackage

// ==== lcd_char_if.sv ====
interface lcd_char_if;
    import scoreboard_pkg::*;

    logic [msg_w-1:0]      msg;        // latched banner
    logic                  line;       // 0 top, 1 bottom
    logic [col_w-1:0]      col;        // 1..16 for characters
    logic [lcd_data_w-1:0] char_code;

    // lookup is combinational, no handshake
    modport requester (
        output msg, line, col,
        input  char_code
    );

    modport provider (
        input  msg, line, col,
        output char_code
    );

endinterface

// ==== player_status.sv ====
module player_status (
    input  logic                              clk,
    input  logic                              rst,
    input  logic [scoreboard_pkg::color_w-1:0] color,
    input  logic [scoreboard_pkg::score_w-1:0] score,
    output logic [scoreboard_pkg::rgb_w-1:0]   led_rgb,
    output logic [scoreboard_pkg::seg_w-1:0]   seg
);
    import scoreboard_pkg::*;

    logic [rgb_w-1:0] rgb_next;
    logic [seg_w-1:0] seg_next;

    // one-hot led, red on the msb
    always_comb begin
        case (color)
            color_red:   rgb_next = 3'b100;
            color_green: rgb_next = 3'b010;
            color_blue:  rgb_next = 3'b001;
            default:     rgb_next = 3'b000; // color_off
        endcase
    end

    // only 1..5 have a digit
    always_comb begin
        if (score >= 3'd1 && score <= 3'd5) begin
            seg_next = seg_digit[score];
        end else begin
            seg_next = seg_blank;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            led_rgb <= '0;
            seg     <= seg_blank;
        end else begin
            led_rgb <= rgb_next;
            seg     <= seg_next;
        end
    end

endmodule

// ==== seg_scanner.sv ====
module seg_scanner (
    input  logic                                clk,
    input  logic                                rst,
    input  logic [scoreboard_pkg::seg_w-1:0]      seg_p1,
    input  logic [scoreboard_pkg::seg_w-1:0]      seg_p2,
    output logic [scoreboard_pkg::seg_w-1:0]      seg_data,
    output logic [scoreboard_pkg::num_digits-1:0] seg_pos
);
    import scoreboard_pkg::*;

    logic [digit_sel_w-1:0] digit_q;
    logic [seg_w-1:0]       pattern;

    // player 1 on the rightmost digit, player 2 on the leftmost
    always_comb begin
        if (digit_q == digit_sel_w'(0)) begin
            pattern = seg_p1;
        end else if (digit_q == digit_sel_w'(num_digits - 1)) begin
            pattern = seg_p2;
        end else begin
            pattern = seg_blank;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            digit_q  <= '0;
            seg_pos  <= '1;         // nothing selected
            seg_data <= seg_blank;
        end else begin
            digit_q  <= digit_q + 1'b1; // wraps after digit 7
            seg_pos  <= ~(num_digits'(1) << digit_q);
            seg_data <= pattern;
        end
    end

endmodule

// ==== lcd_text_rom.sv ====
module lcd_text_rom (
    lcd_char_if.provider char_if
);
    import scoreboard_pkg::*;

    logic                  is_win;
    logic [lcd_data_w-1:0] player_chr;
    logic [lcd_data_w-1:0] top_chr;
    logic [lcd_data_w-1:0] bottom_chr;

    assign is_win     = (char_if.msg == msg_p1_win) || (char_if.msg == msg_p2_win);
    assign player_chr = (char_if.msg == msg_p2_win) ? chr_2 : chr_1;

    // " P1 Win" then padding, col 1 is the first character
    always_comb begin
        case (char_if.col)
            5'd2:    top_chr = chr_p;
            5'd3:    top_chr = player_chr;
            5'd5:    top_chr = chr_w;
            5'd6:    top_chr = chr_i;
            5'd7:    top_chr = chr_n;
            default: top_chr = chr_space;
        endcase
    end

    // two groups of three hearts
    always_comb begin
        case (char_if.col)
            5'd2, 5'd3, 5'd4,
            5'd6, 5'd7, 5'd8: bottom_chr = chr_heart;
            default:          bottom_chr = chr_space;
        endcase
    end

    always_comb begin
        if (!is_win) begin
            char_if.char_code = chr_space; // blank screen
        end else if (char_if.line) begin
            char_if.char_code = bottom_chr;
        end else begin
            char_if.char_code = top_chr;
        end
    end

endmodule

// ==== lcd_sequencer.sv ====
module lcd_sequencer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic [scoreboard_pkg::msg_w-1:0]      lcd_msg,
    lcd_char_if.requester                        char_if,
    output logic                                 lcd_e,
    output logic                                 lcd_rs,
    output logic                                 lcd_rw,
    output logic [scoreboard_pkg::lcd_data_w-1:0] lcd_data
);
    import scoreboard_pkg::*;

    lcd_state_t             state_q;
    lcd_state_t             state_next;
    logic [interval_w-1:0]  interval_q;
    logic [interval_w-1:0]  interval_last;
    logic [msg_w-1:0]       msg_q;
    logic                   wr_en;
    logic                   wr_rs;
    logic [lcd_data_w-1:0]  wr_data;

    // length of each state and where it goes next
    always_comb begin
        case (state_q)
            powerup: begin
                interval_last = interval_w'(powerup_cycles - 1);
                state_next    = function_set;
            end
            function_set: begin
                interval_last = interval_w'(init_cycles - 1);
                state_next    = entry_mode;
            end
            entry_mode: begin
                interval_last = interval_w'(init_cycles - 1);
                state_next    = display_on;
            end
            display_on: begin
                interval_last = interval_w'(init_cycles - 1);
                state_next    = line1;
            end
            line1: begin
                interval_last = interval_w'(line_cycles - 1);
                state_next    = line2;
            end
            line2: begin
                interval_last = interval_w'(line_cycles - 1);
                state_next    = return_home;
            end
            return_home: begin
                interval_last = interval_w'(home_cycles - 1);
                state_next    = clear;
            end
            default: begin // clear
                interval_last = interval_w'(clear_cycles - 1);
                state_next    = line1;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_q    <= powerup;
            interval_q <= '0;
            msg_q      <= '0;
        end else begin
            if (interval_q == interval_last) begin
                state_q    <= state_next;
                interval_q <= '0;
            end else begin
                interval_q <= interval_q + 1'b1;
            end
            if (state_q == line1 && interval_q == '0) begin
                msg_q <= lcd_msg; // one message per refresh
            end
        end
    end

    assign char_if.msg  = msg_q;
    assign char_if.line = (state_q == line2);
    assign char_if.col  = interval_q[col_w-1:0];

    // which byte to write this cycle, if any
    always_comb begin
        wr_en   = 1'b0;
        wr_rs   = 1'b0;
        wr_data = '0;
        case (state_q)
            function_set, entry_mode, display_on, return_home, clear: begin
                wr_en = (interval_q == '0);
                case (state_q)
                    function_set: wr_data = cmd_function_set;
                    entry_mode:   wr_data = cmd_entry_mode;
                    display_on:   wr_data = cmd_display_on;
                    return_home:  wr_data = cmd_return_home;
                    default:      wr_data = cmd_clear;
                endcase
            end
            line1, line2: begin
                wr_en = (interval_q <= interval_w'(lcd_cols));
                if (interval_q == '0) begin
                    wr_data = (state_q == line1) ? cmd_line1_addr : cmd_line2_addr;
                end else begin
                    wr_rs   = 1'b1;
                    wr_data = char_if.char_code;
                end
            end
            default: ; // powerup waits silently
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            lcd_e    <= 1'b0;
            lcd_rs   <= 1'b0;
            lcd_data <= '0;
        end else begin
            lcd_e <= wr_en; // single cycle strobe
            if (wr_en) begin
                lcd_rs   <= wr_rs;
                lcd_data <= wr_data;
            end
        end
    end

    assign lcd_rw = 1'b0; // write only, no busy read

endmodule

// ==== scoreboard_top.sv ====
module scoreboard_top (
    input  logic                                   clk,
    input  logic                                   rst,
    input  logic [scoreboard_pkg::color_w-1:0]     color_1,
    input  logic [scoreboard_pkg::color_w-1:0]     color_2,
    input  logic [scoreboard_pkg::score_w-1:0]     score_1,
    input  logic [scoreboard_pkg::score_w-1:0]     score_2,
    input  logic [scoreboard_pkg::msg_w-1:0]       lcd_msg,
    output logic [scoreboard_pkg::rgb_w-1:0]       led_rgb_1,
    output logic [scoreboard_pkg::rgb_w-1:0]       led_rgb_2,
    output logic [scoreboard_pkg::seg_w-1:0]       seg_data,
    output logic [scoreboard_pkg::num_digits-1:0]  seg_pos,
    output logic                                   lcd_e,
    output logic                                   lcd_rs,
    output logic                                   lcd_rw,
    output logic [scoreboard_pkg::lcd_data_w-1:0]  lcd_data
);
    import scoreboard_pkg::*;

    logic [color_w-1:0] color_arr [num_players];
    logic [score_w-1:0] score_arr [num_players];
    logic [rgb_w-1:0]   rgb_arr   [num_players];
    logic [seg_w-1:0]   seg_arr   [num_players];

    assign color_arr[0] = color_1;
    assign color_arr[1] = color_2;
    assign score_arr[0] = score_1;
    assign score_arr[1] = score_2;
    assign led_rgb_1    = rgb_arr[0];
    assign led_rgb_2    = rgb_arr[1];

    for (genvar i = 0; i < num_players; i++) begin : g_player
        player_status u_player (
            .clk     (clk),
            .rst     (rst),
            .color   (color_arr[i]),
            .score   (score_arr[i]),
            .led_rgb (rgb_arr[i]),
            .seg     (seg_arr[i])
        );
    end

    seg_scanner u_scanner (
        .clk      (clk),
        .rst      (rst),
        .seg_p1   (seg_arr[0]),
        .seg_p2   (seg_arr[1]),
        .seg_data (seg_data),
        .seg_pos  (seg_pos)
    );

    lcd_char_if char_if ();

    lcd_text_rom u_text (
        .char_if (char_if)
    );

    lcd_sequencer u_lcd (
        .clk      (clk),
        .rst      (rst),
        .lcd_msg  (lcd_msg),
        .char_if  (char_if),
        .lcd_e    (lcd_e),
        .lcd_rs   (lcd_rs),
        .lcd_rw   (lcd_rw),
        .lcd_data (lcd_data)
    );

endmodule

// ==== scoreboard_sva.sv ====
module scoreboard_sva (
    input logic                                  clk,
    input logic                                  rst,
    input logic [scoreboard_pkg::num_digits-1:0] seg_pos,
    input logic                                  lcd_e,
    input logic                                  lcd_rs
);
    timeunit 1ns;
    timeprecision 100ps;
    import scoreboard_pkg::*;

    int unsigned strobe_run; // cycles in a row with lcd_e high

    always_ff @(posedge clk) begin
        if (!rst) begin
            strobe_run <= 0;
        end else if (lcd_e) begin
            strobe_run <= strobe_run + 1;
        end else begin
            strobe_run <= 0;
        end
    end

    // scan selects one digit once it has stepped past reset
    one_digit_selected: assert property (
        @(posedge clk) disable iff (!rst) $past(rst) |-> $onehot(~seg_pos)
    ) else $error("seg_pos does not select exactly one digit");

    // a command strobe only runs on into a character byte
    single_strobe: assert property (
        @(posedge clk) disable iff (!rst) lcd_e && !lcd_rs |=> !lcd_e || lcd_rs
    ) else $error("lcd_e held high after a command byte");

    // address plus one line of characters is the longest burst
    strobe_burst: assert property (
        @(posedge clk) disable iff (!rst) lcd_e |-> strobe_run < lcd_cols + 1
    ) else $error("lcd_e high for longer than one line of bytes");

endmodule

bind scoreboard_top scoreboard_sva sva0 (
    .clk     (clk),
    .rst     (rst),
    .seg_pos (seg_pos),
    .lcd_e   (lcd_e),
    .lcd_rs  (lcd_rs)
);

// ==== tb_scoreboard.sv ====
module tb_scoreboard;
    timeunit 1ns;
    timeprecision 100ps;
    import scoreboard_pkg::*;

    localparam int n_led_pairs   = 20;
    localparam int n_score_pairs = 16;
    localparam int score_hold    = 10;
    localparam int frame_cycles  = 2 * line_cycles + home_cycles + clear_cycles;
    localparam int random_cycles = 3 + 2 * n_led_pairs + score_hold * n_score_pairs;
    localparam int cycle_limit   =
        3 * (powerup_cycles + 3 * init_cycles + 3 * frame_cycles + random_cycles) / 2;
    localparam int frame_writes  = 2 * (lcd_cols + 1) + 2; // two lines, home, clear

    logic                  clk;
    logic                  rst;
    logic [color_w-1:0]    color_1;
    logic [color_w-1:0]    color_2;
    logic [score_w-1:0]    score_1;
    logic [score_w-1:0]    score_2;
    logic [msg_w-1:0]      lcd_msg;
    logic [msg_w-1:0]      msg_at_edge; // lcd_msg as seen by the last rising edge
    logic [rgb_w-1:0]      led_rgb_1;
    logic [rgb_w-1:0]      led_rgb_2;
    logic [seg_w-1:0]      seg_data;
    logic [num_digits-1:0] seg_pos;
    logic                  lcd_e;
    logic                  lcd_rs;
    logic                  lcd_rw;
    logic [lcd_data_w-1:0] lcd_data;

    int errors;
    int test_errs;
    int tests_run;
    int tests_failed;
    int cyc;       // rising edges since reset release
    int total_cyc;

    // captured lcd writes
    int                    wr_stamp [$];
    logic [lcd_data_w:0]   wr_byte [$]; // {rs, data}
    logic [msg_w-1:0]      wr_msg [$];

    scoreboard_top dut0 (
        .clk       (clk),
        .rst       (rst),
        .color_1   (color_1),
        .color_2   (color_2),
        .score_1   (score_1),
        .score_2   (score_2),
        .lcd_msg   (lcd_msg),
        .led_rgb_1 (led_rgb_1),
        .led_rgb_2 (led_rgb_2),
        .seg_data  (seg_data),
        .seg_pos   (seg_pos),
        .lcd_e     (lcd_e),
        .lcd_rs    (lcd_rs),
        .lcd_rw    (lcd_rw),
        .lcd_data  (lcd_data)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        msg_at_edge <= lcd_msg;
    end

    // every strobe is one byte on the bus
    always @(negedge clk) begin
        if (rst && lcd_e) begin
            wr_stamp.push_back(cyc);
            wr_byte.push_back({lcd_rs, lcd_data});
            wr_msg.push_back(msg_at_edge);
        end
    end

    initial begin
        total_cyc = 0;
        cyc = 0;
        while (total_cyc <= cycle_limit) begin
            @(posedge clk);
            total_cyc++;
            if (rst)
                cyc++;
        end
        $display("timeout: LCD writes still missing after %0d cycles", cycle_limit);
        $display("SIMULATION FAILED");
        $finish;
    end

    task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (exp !== act) begin
            $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
            errors++;
            test_errs++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errs != 0)
            tests_failed++;
        $display("%s finished with %0d mismatches", name, test_errs);
        test_errs = 0;
    endtask

    task automatic next_cycle();
        @(negedge clk);
        if ($urandom_range(7, 0) == 0)
            lcd_msg = msg_w'($urandom_range(3, 0));
    endtask

    task automatic wait_writes(input int n);
        while (wr_byte.size() < n)
            next_cycle();
    endtask

    function automatic logic [rgb_w-1:0] exp_rgb(input logic [color_w-1:0] c);
        case (c)
            color_red:   return 3'b100;
            color_green: return 3'b010;
            color_blue:  return 3'b001;
            default:     return 3'b000;
        endcase
    endfunction

    function automatic logic [seg_w-1:0] exp_seg(input logic [score_w-1:0] s);
        if (s >= 1 && s <= 5)
            return seg_digit[s];
        return seg_blank;
    endfunction

    // banner text as plain strings, '*' marks a heart
    function automatic logic [lcd_data_w-1:0] exp_char(input logic [msg_w-1:0] msg,
                                                       input int line, input int col);
        string top;
        string bottom;
        int    idx;
        idx    = col - 1;
        top    = (msg == msg_p1_win) ? " P1 Win" : " P2 Win";
        bottom = " *** ***";
        if (msg != msg_p1_win && msg != msg_p2_win)
            return chr_space;
        if (line == 0 && idx < top.len())
            return top.getc(idx);
        if (line == 1 && idx < bottom.len())
            return (bottom.getc(idx) == "*") ? chr_heart : bottom.getc(idx);
        return chr_space;
    endfunction

    task automatic check_write(input string name, input int stamp, input logic rs,
                               input logic [lcd_data_w-1:0] data);
        int                  s;
        logic [lcd_data_w:0] b;
        s = wr_stamp.pop_front();
        b = wr_byte.pop_front();
        void'(wr_msg.pop_front());
        check_val({name, " cycle"}, 32'(stamp), 32'(s));
        check_val(name, 32'({rs, data}), 32'(b));
    endtask

    task automatic reset_test();
        check_val("reset led 1", 32'(rgb_w'(0)), 32'(led_rgb_1));
        check_val("reset led 2", 32'(rgb_w'(0)), 32'(led_rgb_2));
        check_val("reset seg_pos", 32'({num_digits{1'b1}}), 32'(seg_pos));
        check_val("reset seg_data", 32'(seg_blank), 32'(seg_data));
        check_val("reset lcd_e", 32'(1'b0), 32'(lcd_e));
        check_val("reset lcd_rs", 32'(1'b0), 32'(lcd_rs));
        check_val("reset lcd_rw", 32'(1'b0), 32'(lcd_rw));
        check_val("reset lcd_data", 32'(lcd_data_w'(0)), 32'(lcd_data));
        finish_test("reset");
    endtask

    task automatic led_test();
        for (int p = 0; p < n_led_pairs; p++) begin
            color_1 = color_w'($urandom_range(3, 0));
            color_2 = color_w'($urandom_range(3, 0));
            for (int c = 0; c < 2; c++) begin
                next_cycle();
                check_val("led 1", 32'(exp_rgb(color_1)), 32'(led_rgb_1));
                check_val("led 2", 32'(exp_rgb(color_2)), 32'(led_rgb_2));
            end
        end
        finish_test("led colour");
    endtask

    task automatic scan_test();
        int                    digit;
        logic [num_digits-1:0] exp_pos;
        logic [seg_w-1:0]      exp_data;
        digit = (cyc - 1) % num_digits; // counter is 0 at the first edge after reset
        for (int p = 0; p < n_score_pairs; p++) begin
            score_1 = score_w'($urandom_range(7, 0));
            score_2 = score_w'($urandom_range(7, 0));
            for (int c = 1; c <= score_hold; c++) begin
                next_cycle();
                digit   = (digit + 1) % num_digits;
                exp_pos = ~(num_digits'(1) << digit);
                check_val("scan position", 32'(exp_pos), 32'(seg_pos));
                if (c >= 2) begin // two edges from score to display
                    if (digit == 0)
                        exp_data = exp_seg(score_1);
                    else if (digit == num_digits - 1)
                        exp_data = exp_seg(score_2);
                    else
                        exp_data = seg_blank;
                    check_val("scan digit", 32'(exp_data), 32'(seg_data));
                end
            end
        end
        finish_test("score scan");
    endtask

    task automatic init_test();
        int stamp;
        stamp = powerup_cycles + 1;
        wait_writes(4);
        check_write("function set", stamp, 1'b0, cmd_function_set);
        check_write("entry mode", stamp + init_cycles, 1'b0, cmd_entry_mode);
        check_write("display on", stamp + 2 * init_cycles, 1'b0, cmd_display_on);
        // peek only, the refresh test consumes it
        check_val("first line1 address", 32'({1'b0, cmd_line1_addr}), 32'(wr_byte[0]));
        finish_test("init sequence");
    endtask

    task automatic refresh_test();
        int               stamp;
        logic [msg_w-1:0] frame_msg;
        stamp = powerup_cycles + 1 + 3 * init_cycles;
        wait_writes(3 * frame_writes);
        for (int f = 0; f < 3; f++) begin
            frame_msg = wr_msg[0]; // latched with the line1 address
            for (int ln = 0; ln < 2; ln++) begin
                check_write($sformatf("frame %0d line %0d address", f, ln), stamp, 1'b0,
                            (ln == 0) ? cmd_line1_addr : cmd_line2_addr);
                for (int c = 1; c <= lcd_cols; c++) begin
                    check_write($sformatf("frame %0d line %0d col %0d", f, ln, c),
                                stamp + c, 1'b1, exp_char(frame_msg, ln, c));
                end
                stamp += line_cycles;
            end
            check_write($sformatf("frame %0d return home", f), stamp, 1'b0, cmd_return_home);
            stamp += home_cycles;
            check_write($sformatf("frame %0d clear", f), stamp, 1'b0, cmd_clear);
            stamp += clear_cycles;
        end
        finish_test("refresh text");
    endtask

    initial begin
        void'($urandom(32'h0ff812a9));
        errors       = 0;
        test_errs    = 0;
        tests_run    = 0;
        tests_failed = 0;
        rst          = 1'b0;
        color_1      = '0;
        color_2      = '0;
        score_1      = '0;
        score_2      = '0;
        lcd_msg      = '0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset_test();
        rst = 1'b1;
        led_test();
        scan_test();
        init_test();
        refresh_test();
        $display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
        if (errors == 0)
            $display("SIMULATION PASSED");
        else
            $display("SIMULATION FAILED");
        $finish;
    end

endmodule

// ==== tb.f ====
scoreboard_pkg.sv
lcd_char_if.sv
player_status.sv
seg_scanner.sv
lcd_text_rom.sv
lcd_sequencer.sv
scoreboard_top.sv
scoreboard_sva.sv
tb_scoreboard.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_scoreboard -f tb.f -o sim_scoreboard

out=$(./obj_dir/sim_scoreboard)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
